/* common/ldp_cfg_pkg.sv */
// Burst, group and bus width constants for the frame-data writer
// Host address and data word types
// Run-time configuration struct for the ring layout

package ldp_cfg_pkg;

    // Width of the AXI data bus and of every stream word
    localparam int data_w             = 512;
    localparam int bytes_per_beat     = data_w / 8;

    // Frame data goes out in 4 KiB bursts and metadata in 128 byte bursts
    localparam int fd_burst_bytes     = 4096;
    localparam int md_burst_bytes     = 128;
    localparam int fd_beats_per_burst = fd_burst_bytes / bytes_per_beat;
    localparam int md_beats_per_burst = md_burst_bytes / bytes_per_beat;

    // Number of consecutive bursts sent to one frame-data ring before switching
    localparam int bursts_per_group   = 4;

    typedef logic [63:0]       haddr_t;
    typedef logic [data_w-1:0] data_t;

    //==============================
    // Configuration
    //==============================
    // Held stable while out of reset, sampled in reset to load the ring pointers
    typedef struct packed {
        // Frame size in bytes, a whole number of frame-data bursts
        logic [31:0] frame_size;
        haddr_t      fd0_base;
        haddr_t      fd1_base;
        haddr_t      fd_ring_size;
        haddr_t      md0_base;
        haddr_t      md1_base;
        haddr_t      md_ring_size;
        // Host address of the 32-bit frame counter
        haddr_t      fc_addr;
    } ldp_cfg_t;

endpackage

/* common/ldp_axi_pkg.sv */
// Packed structs for the AXI4 write-address and write-data channels
// The ready signals travel as single bits next to these structs

package ldp_axi_pkg;

    import ldp_cfg_pkg::*;

    // Write-address channel as seen by the fabric wrapper
    // Size, burst type, id and the other fixed attributes are set there
    typedef struct packed {
        haddr_t     addr;
        logic [7:0] len;
        logic       valid;
    } axi_aw_t;

    // Write-data channel
    typedef struct packed {
        data_t                     data;
        logic [bytes_per_beat-1:0] strb;
        logic                      last;
        logic                      valid;
    } axi_w_t;

endpackage

/* hw/ldp_ring_addr.sv */
// Next write address for both frame-data rings and the group selection
// Shared offset and addresses for the two metadata rings

`timescale 1ns/100ps

module ldp_ring_addr import ldp_cfg_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  ldp_cfg_t cfg,
    input  logic     fd_advance,
    input  logic     md_advance,
    output haddr_t   fd_addr,
    output haddr_t   md0_addr,
    output haddr_t   md1_addr
);

    // Offset after the current one, wrapping to zero once it passes the ring size
    function automatic haddr_t next_offset(haddr_t cur, haddr_t step, haddr_t size);
        haddr_t nxt;
        nxt = cur + step;
        if (nxt > size) begin
            nxt = '0;
        end
        return nxt;
    endfunction

    //==============================
    // Frame-data rings
    //==============================
    // Counts bursts 1 to 8, the upper half selects ring 1
    logic [$clog2(2*bursts_per_group+1)-1:0] group_cnt;
    logic   group_sel;
    haddr_t fd0_next;
    haddr_t fd1_next;
    haddr_t fd0_cur;
    haddr_t fd1_cur;

    assign group_sel = (group_cnt > bursts_per_group);
    assign fd_addr   = group_sel ? fd1_cur : fd0_cur;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            group_cnt <= 1;
            fd0_next  <= next_offset('0, fd_burst_bytes, cfg.fd_ring_size);
            fd1_next  <= next_offset('0, fd_burst_bytes, cfg.fd_ring_size);
            fd0_cur   <= cfg.fd0_base;
            fd1_cur   <= cfg.fd1_base;
        end else if (fd_advance) begin
            // Only the ring that just took a burst moves on
            if (!group_sel) begin
                fd0_cur  <= cfg.fd0_base + fd0_next;
                fd0_next <= next_offset(fd0_next, fd_burst_bytes, cfg.fd_ring_size);
            end else begin
                fd1_cur  <= cfg.fd1_base + fd1_next;
                fd1_next <= next_offset(fd1_next, fd_burst_bytes, cfg.fd_ring_size);
            end
            // The group cycle runs on across frame boundaries
            if (group_cnt == 2 * bursts_per_group) begin
                group_cnt <= 1;
            end else begin
                group_cnt <= group_cnt + 1'b1;
            end
        end
    end

    //==============================
    // Metadata rings
    //==============================
    // Both copies share one offset, moved once per frame on the counter request
    haddr_t md_next;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            md_next  <= next_offset('0, md_burst_bytes, cfg.md_ring_size);
            md0_addr <= cfg.md0_base;
            md1_addr <= cfg.md1_base;
        end else if (md_advance) begin
            md0_addr <= cfg.md0_base + md_next;
            md1_addr <= cfg.md1_base + md_next;
            md_next  <= next_offset(md_next, md_burst_bytes, cfg.md_ring_size);
        end
    end

    // The AW sequencer requests frame data and the counter write in separate phases
    a_advance_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(fd_advance && md_advance));

endmodule

/* hw/ldp_md_capture.sv */
// Metadata capture, two beats taken from the metadata stream per frame

`timescale 1ns/100ps

module ldp_md_capture import ldp_cfg_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  logic  frame_start,
    input  data_t md_data,
    input  logic  md_valid,
    output logic  md_ready,
    output data_t md_beat0,
    output data_t md_beat1
);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_BEAT0,
        CAP_BEAT1
    } cap_state_t;

    cap_state_t cap_state;
    logic       md_hs;

    // The stream is open only while a capture is in progress
    assign md_ready = (cap_state != CAP_IDLE);
    assign md_hs    = md_valid && md_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cap_state <= CAP_IDLE;
        end else begin
            case (cap_state)
                CAP_IDLE:  if (frame_start) cap_state <= CAP_BEAT0;
                CAP_BEAT0: if (md_hs) cap_state <= CAP_BEAT1;
                CAP_BEAT1: if (md_hs) cap_state <= CAP_IDLE;
                default:   cap_state <= CAP_IDLE;
            endcase
        end
    end

    // Captured words stay put until the next frame overwrites them
    always_ff @(posedge clk) begin
        if (md_hs && cap_state == CAP_BEAT0) begin
            md_beat0 <= md_data;
        end
        if (md_hs && cap_state == CAP_BEAT1) begin
            md_beat1 <= md_data;
        end
    end

    // Metadata for a frame must be in before the next frame's first data beat
    a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        frame_start |-> (cap_state == CAP_IDLE));

endmodule

/* hw/ldp_aw_sequencer.sv */
// AW channel sequencer for one frame
// Frame-data bursts, two metadata copies, then the frame-counter write

`timescale 1ns/100ps

module ldp_aw_sequencer import ldp_cfg_pkg::*, ldp_axi_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  ldp_cfg_t cfg,
    input  logic     idle,
    input  logic     fd_valid,
    input  haddr_t   fd_addr,
    input  haddr_t   md0_addr,
    input  haddr_t   md1_addr,
    output axi_aw_t  aw,
    input  logic     awready,
    output logic     fd_advance,
    output logic     md_advance
);

    typedef enum logic [2:0] {
        AW_FIRST_FD,
        AW_FD,
        AW_MD0,
        AW_MD1,
        AW_FC
    } aw_state_t;

    aw_state_t   aw_state;
    logic [31:0] bursts_per_frame;
    logic [31:0] burst_cnt;
    logic        fd_started;
    logic        aw_hs;
    logic        fd_phase;

    assign bursts_per_frame = cfg.frame_size / fd_burst_bytes;
    assign aw_hs            = aw.valid && awready;
    assign fd_phase         = (aw_state == AW_FIRST_FD) || (aw_state == AW_FD);
    assign fd_advance       = aw_hs && fd_phase;
    assign md_advance       = aw_hs && (aw_state == AW_FC);

    //==============================
    // Request outputs
    //==============================
    always_comb begin
        aw = '0;
        case (aw_state)
            AW_FIRST_FD: begin
                aw.addr  = fd_addr;
                aw.len   = 8'(fd_beats_per_burst - 1);
                // Follows the stream while the W side waits, and stays up once
                // the W side has taken the first beat
                aw.valid = fd_started || (idle && fd_valid);
            end
            AW_FD: begin
                aw.addr  = fd_addr;
                aw.len   = 8'(fd_beats_per_burst - 1);
                aw.valid = 1'b1;
            end
            AW_MD0: begin
                aw.addr  = md0_addr;
                aw.len   = 8'(md_beats_per_burst - 1);
                aw.valid = 1'b1;
            end
            AW_MD1: begin
                aw.addr  = md1_addr;
                aw.len   = 8'(md_beats_per_burst - 1);
                aw.valid = 1'b1;
            end
            AW_FC: begin
                aw.addr  = cfg.fc_addr;
                aw.len   = 8'd0;
                aw.valid = 1'b1;
            end
            default: aw = '0;
        endcase
    end

    //==============================
    // State and burst count
    //==============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_state   <= AW_FIRST_FD;
            burst_cnt  <= '0;
            fd_started <= 1'b0;
        end else begin
            // Remember a first request that was offered but not yet taken
            if (aw_state == AW_FIRST_FD && aw_hs) begin
                fd_started <= 1'b0;
            end else if (aw_state == AW_FIRST_FD && idle && fd_valid) begin
                fd_started <= 1'b1;
            end
            case (aw_state)
                AW_FIRST_FD: if (aw_hs) begin
                    burst_cnt <= 32'd1;
                    aw_state  <= (bursts_per_frame == 32'd1) ? AW_MD0 : AW_FD;
                end
                AW_FD: if (aw_hs) begin
                    if (burst_cnt + 32'd1 == bursts_per_frame) begin
                        aw_state <= AW_MD0;
                    end
                    burst_cnt <= burst_cnt + 32'd1;
                end
                AW_MD0:  if (aw_hs) aw_state <= AW_MD1;
                AW_MD1:  if (aw_hs) aw_state <= AW_FC;
                AW_FC:   if (aw_hs) aw_state <= AW_FIRST_FD;
                default: aw_state <= AW_FIRST_FD;
            endcase
        end
    end

    // A presented request keeps its address and length until it is taken
    a_aw_stable: assert property (@(posedge clk) disable iff (!resetn)
        (aw.valid && !awready) |=> $stable(aw));

endmodule

/* hw/ldp_w_sequencer.sv */
// W channel sequencer and 32-bit frame counter
// Frame data passes straight through, then two metadata copies and the counter beat

`timescale 1ns/100ps

module ldp_w_sequencer import ldp_cfg_pkg::*, ldp_axi_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  ldp_cfg_t cfg,
    input  data_t    fd_data,
    input  logic     fd_valid,
    output logic     fd_ready,
    input  data_t    md_beat0,
    input  data_t    md_beat1,
    output axi_w_t   w,
    input  logic     wready,
    output logic     idle,
    output logic     frame_start
);

    typedef enum logic [2:0] {
        W_IDLE,
        W_FD,
        W_MD00,
        W_MD01,
        W_MD10,
        W_MD11,
        W_FC
    } w_state_t;

    localparam int beat_w = $clog2(fd_beats_per_burst);

    w_state_t          w_state;
    logic [beat_w-1:0] beat_cnt;
    logic [31:0]       burst_cnt;
    logic [31:0]       bursts_per_frame;
    logic [31:0]       frame_cnt;
    logic              w_hs;

    assign bursts_per_frame = cfg.frame_size / fd_burst_bytes;
    assign w_hs             = w.valid && wready;
    assign idle             = (w_state == W_IDLE);
    // The first handshake of a frame happens while still idle
    assign frame_start      = idle && w_hs;

    //==============================
    // Data channel outputs
    //==============================
    always_comb begin
        w        = '0;
        fd_ready = 1'b0;
        case (w_state)
            W_IDLE, W_FD: begin
                // Zero-cycle pass-through from the frame-data stream
                w.data   = fd_data;
                w.strb   = '1;
                w.valid  = fd_valid;
                fd_ready = wready;
                w.last   = (w_state == W_FD) && fd_valid &&
                           (beat_cnt == beat_w'(fd_beats_per_burst - 1));
            end
            W_MD00, W_MD10: begin
                w.data  = md_beat0;
                w.strb  = '1;
                w.valid = 1'b1;
            end
            W_MD01, W_MD11: begin
                w.data  = md_beat1;
                w.strb  = '1;
                w.last  = 1'b1;
                w.valid = 1'b1;
            end
            W_FC: begin
                // Counter written twice side by side in the low 64 bits
                w.data  = data_t'({frame_cnt, frame_cnt});
                w.strb  = {{(bytes_per_beat - 8){1'b0}}, 8'hff};
                w.last  = 1'b1;
                w.valid = 1'b1;
            end
            default: w = '0;
        endcase
    end

    //==============================
    // State, beat and burst counts
    //==============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            w_state   <= W_IDLE;
            beat_cnt  <= '0;
            burst_cnt <= '0;
            frame_cnt <= '0;
        end else begin
            case (w_state)
                W_IDLE: if (frame_start) begin
                    frame_cnt <= frame_cnt + 32'd1;
                    beat_cnt  <= beat_w'(1);
                    burst_cnt <= '0;
                    w_state   <= W_FD;
                end
                W_FD: if (w_hs) begin
                    beat_cnt <= w.last ? '0 : beat_cnt + 1'b1;
                    if (w.last) begin
                        // Last beat of the last burst ends the frame data
                        if (burst_cnt + 32'd1 == bursts_per_frame) begin
                            w_state <= W_MD00;
                        end
                        burst_cnt <= burst_cnt + 32'd1;
                    end
                end
                W_MD00:  if (w_hs) w_state <= W_MD01;
                W_MD01:  if (w_hs) w_state <= W_MD10;
                W_MD10:  if (w_hs) w_state <= W_MD11;
                W_MD11:  if (w_hs) w_state <= W_FC;
                W_FC:    if (w_hs) w_state <= W_IDLE;
                default: w_state <= W_IDLE;
            endcase
        end
    end

    // An offered beat and its burst marking hold until the slave takes it
    a_w_stable: assert property (@(posedge clk) disable iff (!resetn)
        (w.valid && !wready) |=> $stable(w));

endmodule

/* hw/ldp_manager.sv */
// Top level of the frame-data writer
// Connects ring addressing, metadata capture and the AW and W sequencers

`timescale 1ns/100ps

module ldp_manager import ldp_cfg_pkg::*, ldp_axi_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  ldp_cfg_t cfg,
    // Frame-data stream
    input  data_t    fd_data,
    input  logic     fd_valid,
    output logic     fd_ready,
    // Metadata stream
    input  data_t    md_data,
    input  logic     md_valid,
    output logic     md_ready,
    // AXI4 write master
    output axi_aw_t  aw,
    input  logic     awready,
    output axi_w_t   w,
    input  logic     wready,
    output logic     bready
);

    logic   idle;
    logic   frame_start;
    logic   fd_advance;
    logic   md_advance;
    haddr_t fd_addr;
    haddr_t md0_addr;
    haddr_t md1_addr;
    data_t  md_beat0;
    data_t  md_beat1;

    // Write responses are accepted and dropped
    assign bready = 1'b1;

    ldp_ring_addr ring_addr0 (
        .clk, .resetn, .cfg,
        .fd_advance, .md_advance,
        .fd_addr, .md0_addr, .md1_addr
    );

    ldp_md_capture md_capture0 (
        .clk, .resetn, .frame_start,
        .md_data, .md_valid, .md_ready,
        .md_beat0, .md_beat1
    );

    ldp_aw_sequencer aw_seq0 (
        .clk, .resetn, .cfg,
        .idle, .fd_valid,
        .fd_addr, .md0_addr, .md1_addr,
        .aw, .awready,
        .fd_advance, .md_advance
    );

    ldp_w_sequencer w_seq0 (
        .clk, .resetn, .cfg,
        .fd_data, .fd_valid, .fd_ready,
        .md_beat0, .md_beat1,
        .w, .wready,
        .idle, .frame_start
    );

endmodule

/* tests/tb_ldp_manager.sv */
// Testbench for the frame-data writer top level
// AXI slave model with random back-pressure, stream drivers, reference functions
// and compare tasks for the logged AW requests and W beats

`timescale 1ns/100ps

module tb_ldp_manager import ldp_cfg_pkg::*, ldp_axi_pkg::*; ();

    localparam int     n_frames      = 6;
    localparam int     frame_bytes   = 8192;
    localparam int     fd_bursts     = frame_bytes / fd_burst_bytes;
    localparam int     fd_beats      = fd_bursts * fd_beats_per_burst;
    // Per frame: data bursts, two metadata copies and the counter write
    localparam int     aw_per_frame  = fd_bursts + 3;
    localparam int     w_per_frame   = fd_beats + 2 * md_beats_per_burst + 1;
    localparam int     total_aw      = n_frames * aw_per_frame;
    localparam int     total_w       = n_frames * w_per_frame;
    localparam int     wait_limit    = 4000;
    localparam int     sample_delay  = 40;
    localparam haddr_t fd0_base      = 64'h0000_0010_0000_0000;
    localparam haddr_t fd1_base      = 64'h0000_0020_0000_0000;
    localparam haddr_t md0_base      = 64'h0000_0030_0000_0000;
    localparam haddr_t md1_base      = 64'h0000_0031_0000_0000;
    localparam haddr_t fc_addr       = 64'h0000_0040_0000_0100;
    localparam haddr_t fd_ring_bytes = 64'd8192;
    localparam haddr_t md_ring_bytes = 64'd256;

    logic     clk;
    logic     resetn;
    ldp_cfg_t cfg;
    data_t    fd_data;
    logic     fd_valid;
    logic     fd_ready;
    data_t    md_data;
    logic     md_valid;
    logic     md_ready;
    axi_aw_t  aw;
    logic     awready;
    axi_w_t   w;
    logic     wready;
    logic     bready;

    // Stimulus words and what the slave model has seen
    data_t   fd_words [n_frames * fd_beats];
    data_t   md_words [n_frames * 2];
    axi_aw_t aw_log [$];
    axi_w_t  w_log [$];
    int      credit;
    int      fd_count;
    int      md_count;
    int      aw_done;
    int      w_done;
    logic    traffic_on;
    int      checks [1:6];
    int      errs [1:6];

    always #50 clk = ~clk;

    ldp_manager dut0 (
        .clk, .resetn, .cfg,
        .fd_data, .fd_valid, .fd_ready,
        .md_data, .md_valid, .md_ready,
        .aw, .awready,
        .w, .wready,
        .bready
    );

    //==============================
    // Reference model
    //==============================
    // Offset of the n-th burst into a ring, back to zero once it would pass the size
    function automatic haddr_t ring_offset(int n, haddr_t step, haddr_t size);
        haddr_t off;
        int     i;
        off = '0;
        for (i = 0; i < n; i++) begin
            off = off + step;
            if (off > size) begin
                off = '0;
            end
        end
        return off;
    endfunction

    // The k-th write request of the whole run
    function automatic axi_aw_t expected_aw(int k);
        axi_aw_t want;
        int      f;
        int      s;
        int      g;
        int      grp;
        f    = k / aw_per_frame;
        s    = k % aw_per_frame;
        want = '0;
        want.valid = 1'b1;
        if (s < fd_bursts) begin
            // Groups of four alternate between the rings, each ring counts its own bursts
            g   = f * fd_bursts + s;
            grp = g / bursts_per_group;
            want.addr = ((grp % 2) ? fd1_base : fd0_base) +
                        ring_offset((grp / 2) * bursts_per_group + g % bursts_per_group,
                                    fd_burst_bytes, fd_ring_bytes);
            want.len  = 8'd63;
        end else if (s == fd_bursts) begin
            want.addr = md0_base + ring_offset(f, md_burst_bytes, md_ring_bytes);
            want.len  = 8'd1;
        end else if (s == fd_bursts + 1) begin
            want.addr = md1_base + ring_offset(f, md_burst_bytes, md_ring_bytes);
            want.len  = 8'd1;
        end else begin
            want.addr = fc_addr;
            want.len  = 8'd0;
        end
        return want;
    endfunction

    // The k-th write beat of the whole run
    function automatic axi_w_t expected_w(int k);
        axi_w_t want;
        int     f;
        int     s;
        f    = k / w_per_frame;
        s    = k % w_per_frame;
        want = '0;
        want.valid = 1'b1;
        if (s < fd_beats) begin
            want.data = fd_words[f * fd_beats + s];
            want.strb = '1;
            want.last = (s % 64 == 63);
        end else if (s < fd_beats + 4) begin
            // Beat0, beat1, then the same pair again for the second copy
            want.data = md_words[2 * f + (s - fd_beats) % 2];
            want.strb = '1;
            want.last = ((s - fd_beats) % 2 == 1);
        end else begin
            want.data[31:0]  = 32'(f + 1);
            want.data[63:32] = 32'(f + 1);
            want.strb[7:0]   = 8'hff;
            want.last        = 1'b1;
        end
        return want;
    endfunction

    //==============================
    // Compare tasks
    //==============================
    task automatic compare_aw(input int cat, input int idx, input axi_aw_t got,
                              input axi_aw_t want);
        checks[cat]++;
        if (got.addr !== want.addr) begin
            $display("FAIL aw.addr request %0d: got 0x%h expected 0x%h",
                     idx, got.addr, want.addr);
            errs[cat]++;
        end
        if (got.len !== want.len) begin
            $display("FAIL aw.len request %0d: got 0x%h expected 0x%h",
                     idx, got.len, want.len);
            errs[cat]++;
        end
    endtask

    task automatic compare_w(input int cat, input int idx, input axi_w_t got,
                             input axi_w_t want);
        checks[cat]++;
        if (got.data !== want.data) begin
            $display("FAIL w.data beat %0d: got 0x%h expected 0x%h",
                     idx, got.data, want.data);
            errs[cat]++;
        end
        if (got.strb !== want.strb) begin
            $display("FAIL w.strb beat %0d: got 0x%h expected 0x%h",
                     idx, got.strb, want.strb);
            errs[cat]++;
        end
        if (got.last !== want.last) begin
            $display("FAIL w.last beat %0d: got 0x%h expected 0x%h",
                     idx, got.last, want.last);
            errs[cat]++;
        end
    endtask

    task automatic compare_addr(input int cat, input string name, input haddr_t got,
                                input haddr_t want);
        checks[cat]++;
        if (got !== want) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, want);
            errs[cat]++;
        end
    endtask

    task automatic compare_bit(input int cat, input string name, input logic got,
                               input logic want);
        checks[cat]++;
        if (got !== want) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, want);
            errs[cat]++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    //==============================
    // AXI slave model
    //==============================
    always @(negedge clk) begin : drive_ready
        logic take_aw;
        logic take_w;
        take_aw = ($urandom % 4) != 0;
        take_w  = ($urandom % 4) != 0;
        if (!traffic_on) begin
            awready = 1'b0;
            wready  = 1'b0;
        end else begin
            awready = take_aw;
            // With no accepted request left to fill, a W beat only goes
            // together with the request that covers it
            wready  = (credit > 0) ? take_w : take_aw;
        end
    end

    // Handshakes are taken just before the rising edge, once everything has settled
    always @(negedge clk) begin
        #sample_delay;
        if (resetn) begin
            if (aw.valid && awready) begin
                aw_log.push_back(aw);
                credit = credit + aw.len + 1;
            end
            if (w.valid && wready) begin
                w_log.push_back(w);
                credit = credit - 1;
            end
            if (fd_valid && fd_ready) begin
                fd_count++;
            end
            if (md_valid && md_ready) begin
                md_count++;
            end
        end
    end

    // Checks logged items against the reference in arrival order
    always @(negedge clk) begin : compare_logs
        axi_aw_t aw_item;
        axi_w_t  w_item;
        int      s;
        while (aw_log.size() > 0) begin
            aw_item = aw_log.pop_front();
            if (aw_done >= total_aw) begin
                $display("Unexpected write request to 0x%h after the last frame", aw_item.addr);
                errs[6]++;
            end else begin
                s = aw_done % aw_per_frame;
                compare_aw((s < fd_bursts) ? 1 : ((s < fd_bursts + 2) ? 3 : 4),
                           aw_done, aw_item, expected_aw(aw_done));
                // Both copies must sit at the offset this frame owns
                if (s == fd_bursts) begin
                    compare_addr(5, "metadata ring 0 offset", aw_item.addr - md0_base,
                                 ring_offset(aw_done / aw_per_frame, md_burst_bytes,
                                             md_ring_bytes));
                end
                if (s == fd_bursts + 1) begin
                    compare_addr(5, "metadata ring 1 offset", aw_item.addr - md1_base,
                                 ring_offset(aw_done / aw_per_frame, md_burst_bytes,
                                             md_ring_bytes));
                end
            end
            aw_done++;
        end
        while (w_log.size() > 0) begin
            w_item = w_log.pop_front();
            if (w_done >= total_w) begin
                $display("Unexpected write beat after the last frame");
                errs[6]++;
            end else begin
                s = w_done % w_per_frame;
                compare_w((s < fd_beats) ? 2 : ((s < fd_beats + 4) ? 3 : 4),
                          w_done, w_item, expected_w(w_done));
            end
            w_done++;
        end
    end

    //==============================
    // Stream drivers
    //==============================
    function automatic data_t random_word();
        data_t word;
        int    j;
        for (j = 0; j < data_w / 32; j++) begin
            word[j*32 +: 32] = $urandom;
        end
        return word;
    endfunction

    task automatic drive_frame_data();
        int i;
        int t;
        @(negedge clk);
        for (i = 0; i < n_frames * fd_beats; i++) begin
            // Random idle cycles between words
            while (($urandom % 4) == 0) begin
                fd_valid = 1'b0;
                @(negedge clk);
            end
            fd_valid = 1'b1;
            fd_data  = fd_words[i];
            t = 0;
            @(negedge clk);
            while (fd_count <= i) begin
                t++;
                if (t > wait_limit) begin
                    abort_on_timeout("a frame-data stream handshake");
                end
                @(negedge clk);
            end
        end
        fd_valid = 1'b0;
    endtask

    // Two metadata words per frame, offered once the frame's first word is taken
    task automatic drive_metadata();
        int f;
        int b;
        int t;
        @(negedge clk);
        for (f = 0; f < n_frames; f++) begin
            t = 0;
            while (fd_count <= f * fd_beats) begin
                t++;
                if (t > wait_limit) begin
                    abort_on_timeout("the first data word of a frame");
                end
                @(negedge clk);
            end
            for (b = 0; b < 2; b++) begin
                md_valid = 1'b1;
                md_data  = md_words[2 * f + b];
                t = 0;
                @(negedge clk);
                while (md_count <= 2 * f + b) begin
                    t++;
                    if (t > wait_limit) begin
                        abort_on_timeout("a metadata stream handshake");
                    end
                    @(negedge clk);
                end
            end
            md_valid = 1'b0;
        end
    endtask

    //==============================
    // Main sequence
    //==============================
    initial begin : run_test
        int i;
        int t;
        int seed_ret;
        int total_checks;
        int total_errs;
        clk        = 1'b0;
        resetn     = 1'b0;
        fd_data    = '0;
        fd_valid   = 1'b0;
        md_data    = '0;
        md_valid   = 1'b0;
        awready    = 1'b0;
        wready     = 1'b0;
        traffic_on = 1'b0;
        cfg              = '0;
        cfg.frame_size   = 32'(frame_bytes);
        cfg.fd0_base     = fd0_base;
        cfg.fd1_base     = fd1_base;
        cfg.fd_ring_size = fd_ring_bytes;
        cfg.md0_base     = md0_base;
        cfg.md1_base     = md1_base;
        cfg.md_ring_size = md_ring_bytes;
        cfg.fc_addr      = fc_addr;
        seed_ret = $urandom(32'h741f915d);
        for (i = 0; i < n_frames * fd_beats; i++) begin
            fd_words[i] = random_word();
        end
        for (i = 0; i < n_frames * 2; i++) begin
            md_words[i] = random_word();
        end

        repeat (8) @(negedge clk);
        resetn = 1'b1;
        #sample_delay;
        compare_bit(6, "aw.valid after reset", aw.valid, 1'b0);
        compare_bit(6, "w.valid after reset", w.valid, 1'b0);
        compare_bit(6, "fd_ready after reset", fd_ready, 1'b0);
        compare_bit(6, "md_ready after reset", md_ready, 1'b0);
        compare_bit(6, "bready", bready, 1'b1);
        traffic_on = 1'b1;

        fork
            drive_frame_data();
            drive_metadata();
        join

        t = 0;
        while (aw_done < total_aw || w_done < total_w) begin
            t++;
            if (t > wait_limit) begin
                abort_on_timeout("the last frame-counter write");
            end
            @(posedge clk);
        end
        checks[6]++;
        // Short quiet window so that stray requests or beats get flagged
        repeat (16) @(posedge clk);

        $display("Behavior 1 frame-data requests and ring wrap: %0d checks, %0d errors",
                 checks[1], errs[1]);
        $display("Behavior 2 frame-data beats: %0d checks, %0d errors", checks[2], errs[2]);
        $display("Behavior 3 metadata copies: %0d checks, %0d errors", checks[3], errs[3]);
        $display("Behavior 4 frame-counter write: %0d checks, %0d errors", checks[4], errs[4]);
        $display("Behavior 5 metadata offset: %0d checks, %0d errors", checks[5], errs[5]);
        $display("Behavior 6 reset levels and back-pressure run: %0d checks, %0d errors",
                 checks[6], errs[6]);
        total_checks = 0;
        total_errs   = 0;
        for (i = 1; i <= 6; i++) begin
            total_checks += checks[i];
            total_errs   += errs[i];
        end
        $display("Checks: %0d, errors: %0d", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
common/ldp_cfg_pkg.sv
common/ldp_axi_pkg.sv
hw/ldp_ring_addr.sv
hw/ldp_md_capture.sv
hw/ldp_aw_sequencer.sv
hw/ldp_w_sequencer.sv
hw/ldp_manager.sv
tests/tb_ldp_manager.sv

/* Bender.yml */
package:
  name: ldp_manager

sources:
  - files:
      - common/ldp_cfg_pkg.sv
      - common/ldp_axi_pkg.sv
      - hw/ldp_ring_addr.sv
      - hw/ldp_md_capture.sv
      - hw/ldp_aw_sequencer.sv
      - hw/ldp_w_sequencer.sv
      - hw/ldp_manager.sv
  - target: test
    files:
      - tests/tb_ldp_manager.sv
